// ==== files.f ====
src/video_pkg.sv
src/lut_ram.sv
src/lookup_map.sv
src/chroma_offset.sv
src/di_return_mux.sv
src/video_pipe.sv
tb/clock_gen.sv
tb/tb_video_pipe.sv

// ==== src/chroma_offset.sv ====
module chroma_offset (
   input  logic                  di_clk,
   input  logic                  resetb_clk,

   input  video_pkg::term_addr_t di_term_addr,
   input  video_pkg::reg_addr_t  di_reg_addr,
   input  logic                  di_read_mode,
   input  logic                  di_read_req,
   input  logic                  di_write_mode,
   input  logic                  di_write,
   input  video_pkg::di_data_t   di_reg_datai,
   output logic                  di_read_rdy,
   output video_pkg::di_data_t   di_reg_datao,
   output logic                  di_write_rdy,
   output logic                  di_claim,

   input  logic                  dvi,
   input  video_pkg::dtype_t     dtypei,
   input  video_pkg::pixel_t     y,
   input  video_pkg::pixel_t     u,
   input  video_pkg::pixel_t     v,
   input  video_pkg::meta_t      meta_datai,
   output logic                  dvo,
   output video_pkg::dtype_t     dtypeo,
   output video_pkg::pixel_t     yo,
   output video_pkg::pixel_t     uo,
   output video_pkg::pixel_t     vo,
   output video_pkg::meta_t      meta_datao
);

   localparam int PAD_WIDTH = video_pkg::DI_DATA_WIDTH - video_pkg::PIXEL_WIDTH;

   logic                hit;
   logic                rd_hit;
   video_pkg::pixel_t   u_offset;
   video_pkg::pixel_t   v_offset;
   video_pkg::di_data_t rd_data;

   // two's complement add, clamped to the range of one component.
   function automatic video_pkg::pixel_t sat_add(input video_pkg::pixel_t a,
                                                 input video_pkg::pixel_t b);
      logic [video_pkg::PIXEL_WIDTH:0] sum;
      sum = {a[video_pkg::PIXEL_WIDTH-1], a} + {b[video_pkg::PIXEL_WIDTH-1], b};
      if (sum[video_pkg::PIXEL_WIDTH] != sum[video_pkg::PIXEL_WIDTH-1]) begin
         // overflow, so the extra sign bit tells which rail to take.
         sat_add = sum[video_pkg::PIXEL_WIDTH] ? {1'b1, {(video_pkg::PIXEL_WIDTH-1){1'b0}}}
                                               : {1'b0, {(video_pkg::PIXEL_WIDTH-1){1'b1}}};
      end else begin
         sat_add = sum[video_pkg::PIXEL_WIDTH-1:0];
      end
   endfunction

   assign hit = (di_term_addr == video_pkg::TERM_CHROMA_OFFSET);
   assign rd_hit = hit && di_read_mode && di_read_req;

   always_comb begin
      rd_data = '0;   // unused register numbers read as zero.
      if (di_reg_addr == video_pkg::REG_U_OFFSET) begin
         rd_data = {{PAD_WIDTH{u_offset[video_pkg::PIXEL_WIDTH-1]}}, u_offset};
      end else if (di_reg_addr == video_pkg::REG_V_OFFSET) begin
         rd_data = {{PAD_WIDTH{v_offset[video_pkg::PIXEL_WIDTH-1]}}, v_offset};
      end
   end

   always_ff @(posedge di_clk or negedge resetb_clk) begin
      if (!resetb_clk) begin
         u_offset     <= '0;
         v_offset     <= '0;
         di_read_rdy  <= 1'b0;
         di_reg_datao <= '0;
         di_write_rdy <= 1'b0;
         di_claim     <= 1'b0;
      end else begin
         if (hit && di_write && di_reg_addr == video_pkg::REG_U_OFFSET) begin
            u_offset <= di_reg_datai[video_pkg::PIXEL_WIDTH-1:0];
         end
         if (hit && di_write && di_reg_addr == video_pkg::REG_V_OFFSET) begin
            v_offset <= di_reg_datai[video_pkg::PIXEL_WIDTH-1:0];
         end
         di_claim     <= hit;
         di_write_rdy <= hit && di_write_mode;
         di_read_rdy  <= rd_hit;
         if (rd_hit) begin
            di_reg_datao <= rd_data;
         end
      end
   end

   always_ff @(posedge di_clk or negedge resetb_clk) begin
      if (!resetb_clk) begin
         dvo        <= 1'b0;
         dtypeo     <= '0;
         yo         <= '0;
         uo         <= '0;
         vo         <= '0;
         meta_datao <= '0;
      end else begin
         dvo        <= dvi;
         dtypeo     <= dtypei;
         yo         <= y;
         uo         <= sat_add(u, u_offset);
         vo         <= sat_add(v, v_offset);
         meta_datao <= meta_datai;
      end
   end

endmodule

// ==== src/di_return_mux.sv ====
module di_return_mux (
   input  logic                lm_read_rdy,
   input  video_pkg::di_data_t lm_reg_datao,
   input  logic                lm_write_rdy,
   input  logic                lm_claim,

   input  logic                co_read_rdy,
   input  video_pkg::di_data_t co_reg_datao,
   input  logic                co_write_rdy,
   input  logic                co_claim,

   output logic                di_read_rdy,
   output video_pkg::di_data_t di_reg_datao,
   output logic                di_write_rdy,
   output logic                di_en,
   output video_pkg::status_t  di_transfer_status
);

   logic any_claim;

   assign any_claim = lm_claim || co_claim;

   assign di_read_rdy = lm_read_rdy || co_read_rdy;
   assign di_write_rdy = lm_write_rdy || co_write_rdy;
   assign di_en = any_claim;

   // at most one terminal claims a given address.
   always_comb begin
      if (co_claim) begin
         di_reg_datao = co_reg_datao;
      end else if (lm_claim) begin
         di_reg_datao = lm_reg_datao;
      end else begin
         di_reg_datao = '0;
      end
   end

   assign di_transfer_status = any_claim ? video_pkg::STATUS_OK : video_pkg::STATUS_NO_TERM;

endmodule

// ==== src/lookup_map.sv ====
module lookup_map (
   input  logic                  di_clk,
   input  logic                  resetb_clk,
   input  logic                  lut_enable,

   input  video_pkg::term_addr_t di_term_addr,
   input  video_pkg::reg_addr_t  di_reg_addr,
   input  logic                  di_read_mode,
   input  logic                  di_read_req,
   input  logic                  di_write_mode,
   input  logic                  di_write,
   input  video_pkg::di_data_t   di_reg_datai,
   output logic                  di_read_rdy,
   output video_pkg::di_data_t   di_reg_datao,
   output logic                  di_write_rdy,
   output logic                  di_claim,

   input  logic                  dvi,
   input  video_pkg::dtype_t     dtypei,
   input  video_pkg::pixel_t     y,
   input  video_pkg::pixel_t     u,
   input  video_pkg::pixel_t     v,
   input  video_pkg::meta_t      meta_datai,
   output logic                  dvo,
   output video_pkg::dtype_t     dtypeo,
   output video_pkg::pixel_t     yo,
   output video_pkg::pixel_t     uo,
   output video_pkg::pixel_t     vo,
   output video_pkg::meta_t      meta_datao
);

   localparam int PAD_WIDTH = video_pkg::DI_DATA_WIDTH - video_pkg::PIXEL_WIDTH;

   logic                                 hit;
   logic                                 rd_hit;
   logic                                 ram_we;
   logic [video_pkg::LUT_ADDR_WIDTH-1:0] ram_addr;
   video_pkg::pixel_t                    ram_q;

   // first pipeline stage, lined up with the RAM read.
   logic                                 dv_d;
   logic                                 lut_en_d;
   video_pkg::dtype_t                    dtype_d;
   video_pkg::pixel_t                    y_d;
   video_pkg::pixel_t                    u_d;
   video_pkg::pixel_t                    v_d;
   video_pkg::meta_t                     meta_d;

   assign hit = (di_term_addr == video_pkg::TERM_LOOKUP_MAP);
   assign rd_hit = hit && di_read_mode && di_read_req;
   assign ram_we = hit && di_write;

   // a bus access takes the RAM port away from the pixel stream.
   assign ram_addr = (hit && (di_read_mode || di_write_mode)) ?
                     di_reg_addr[video_pkg::LUT_ADDR_WIDTH-1:0] : y;

   lut_ram u_lut_ram (
      .di_clk (di_clk),
      .addr   (ram_addr),
      .we     (ram_we),
      .datai  (di_reg_datai[video_pkg::PIXEL_WIDTH-1:0]),
      .datao  (ram_q)
   );

   always_ff @(posedge di_clk or negedge resetb_clk) begin
      if (!resetb_clk) begin
         di_read_rdy  <= 1'b0;
         di_reg_datao <= '0;
         di_write_rdy <= 1'b0;
         di_claim     <= 1'b0;
      end else begin
         di_claim     <= hit;
         di_write_rdy <= hit && di_write_mode;
         di_read_rdy  <= rd_hit;
         if (rd_hit) begin
            di_reg_datao <= {{PAD_WIDTH{1'b0}}, ram_q};   // address was held a cycle early.
         end
      end
   end

   always_ff @(posedge di_clk) begin
      dtype_d <= dtypei;
      y_d     <= y;
      u_d     <= u;
      v_d     <= v;
      meta_d  <= meta_datai;
   end

   always_ff @(posedge di_clk or negedge resetb_clk) begin
      if (!resetb_clk) begin
         dv_d       <= 1'b0;
         lut_en_d   <= 1'b0;
         dvo        <= 1'b0;
         dtypeo     <= '0;
         yo         <= '0;
         uo         <= '0;
         vo         <= '0;
         meta_datao <= '0;
      end else begin
         dv_d       <= dvi;
         lut_en_d   <= lut_enable;   // the enable travels with its own beat.
         dvo        <= dv_d;
         dtypeo     <= dtype_d;
         yo         <= lut_en_d ? ram_q : y_d;
         uo         <= u_d;
         vo         <= v_d;
         meta_datao <= meta_d;
      end
   end

endmodule

// ==== src/lut_ram.sv ====
module lut_ram (
   input  logic                                 di_clk,
   input  logic [video_pkg::LUT_ADDR_WIDTH-1:0] addr,
   input  logic                                 we,
   input  video_pkg::pixel_t                    datai,
   output video_pkg::pixel_t                    datao
);

   video_pkg::pixel_t mem [video_pkg::LUT_DEPTH];

   // the read returns the old entry when a write hits the same address.
   always_ff @(posedge di_clk) begin
      if (we) begin
         mem[addr] <= datai;
      end
      datao <= mem[addr];
   end

endmodule

// ==== src/video_pipe.sv ====
module video_pipe (
   input  logic                  di_clk,
   input  logic                  resetb_clk,
   input  logic                  lut_enable,

   input  video_pkg::term_addr_t di_term_addr,
   input  video_pkg::reg_addr_t  di_reg_addr,
   input  logic                  di_read_mode,
   input  logic                  di_read_req,
   input  logic                  di_write_mode,
   input  logic                  di_write,
   input  video_pkg::di_data_t   di_reg_datai,
   output logic                  di_read_rdy,
   output video_pkg::di_data_t   di_reg_datao,
   output logic                  di_write_rdy,
   output logic                  di_en,
   output video_pkg::status_t    di_transfer_status,

   input  logic                  dvi,
   input  video_pkg::dtype_t     dtypei,
   input  video_pkg::pixel_t     y,
   input  video_pkg::pixel_t     u,
   input  video_pkg::pixel_t     v,
   input  video_pkg::meta_t      meta_datai,
   output logic                  dvo,
   output video_pkg::dtype_t     dtypeo,
   output video_pkg::pixel_t     yo,
   output video_pkg::pixel_t     uo,
   output video_pkg::pixel_t     vo,
   output video_pkg::meta_t      meta_datao
);

   // bus returns of each terminal.
   logic                lm_read_rdy;
   video_pkg::di_data_t lm_reg_datao;
   logic                lm_write_rdy;
   logic                lm_claim;
   logic                co_read_rdy;
   video_pkg::di_data_t co_reg_datao;
   logic                co_write_rdy;
   logic                co_claim;

   // pixel beat between the two stages.
   logic                lm_dvo;
   video_pkg::dtype_t   lm_dtypeo;
   video_pkg::pixel_t   lm_yo;
   video_pkg::pixel_t   lm_uo;
   video_pkg::pixel_t   lm_vo;
   video_pkg::meta_t    lm_meta_datao;

   lookup_map u_lookup_map (
      .di_clk        (di_clk),
      .resetb_clk    (resetb_clk),
      .lut_enable    (lut_enable),
      .di_term_addr  (di_term_addr),
      .di_reg_addr   (di_reg_addr),
      .di_read_mode  (di_read_mode),
      .di_read_req   (di_read_req),
      .di_write_mode (di_write_mode),
      .di_write      (di_write),
      .di_reg_datai  (di_reg_datai),
      .di_read_rdy   (lm_read_rdy),
      .di_reg_datao  (lm_reg_datao),
      .di_write_rdy  (lm_write_rdy),
      .di_claim      (lm_claim),
      .dvi           (dvi),
      .dtypei        (dtypei),
      .y             (y),
      .u             (u),
      .v             (v),
      .meta_datai    (meta_datai),
      .dvo           (lm_dvo),
      .dtypeo        (lm_dtypeo),
      .yo            (lm_yo),
      .uo            (lm_uo),
      .vo            (lm_vo),
      .meta_datao    (lm_meta_datao)
   );

   chroma_offset u_chroma_offset (
      .di_clk        (di_clk),
      .resetb_clk    (resetb_clk),
      .di_term_addr  (di_term_addr),
      .di_reg_addr   (di_reg_addr),
      .di_read_mode  (di_read_mode),
      .di_read_req   (di_read_req),
      .di_write_mode (di_write_mode),
      .di_write      (di_write),
      .di_reg_datai  (di_reg_datai),
      .di_read_rdy   (co_read_rdy),
      .di_reg_datao  (co_reg_datao),
      .di_write_rdy  (co_write_rdy),
      .di_claim      (co_claim),
      .dvi           (lm_dvo),
      .dtypei        (lm_dtypeo),
      .y             (lm_yo),
      .u             (lm_uo),
      .v             (lm_vo),
      .meta_datai    (lm_meta_datao),
      .dvo           (dvo),
      .dtypeo        (dtypeo),
      .yo            (yo),
      .uo            (uo),
      .vo            (vo),
      .meta_datao    (meta_datao)
   );

   di_return_mux u_di_return_mux (
      .lm_read_rdy        (lm_read_rdy),
      .lm_reg_datao       (lm_reg_datao),
      .lm_write_rdy       (lm_write_rdy),
      .lm_claim           (lm_claim),
      .co_read_rdy        (co_read_rdy),
      .co_reg_datao       (co_reg_datao),
      .co_write_rdy       (co_write_rdy),
      .co_claim           (co_claim),
      .di_read_rdy        (di_read_rdy),
      .di_reg_datao       (di_reg_datao),
      .di_write_rdy       (di_write_rdy),
      .di_en              (di_en),
      .di_transfer_status (di_transfer_status)
   );

endmodule

// ==== src/video_pkg.sv ====
package video_pkg;

   // component and sideband widths of a pixel beat.
   localparam int PIXEL_WIDTH = 8;
   localparam int DTYPE_WIDTH = 3;
   localparam int META_WIDTH = 16;

   // the table is indexed directly by y.
   localparam int LUT_ADDR_WIDTH = 8;
   localparam int LUT_DEPTH = 1 << LUT_ADDR_WIDTH;

   // DI bus field widths.
   localparam int TERM_ADDR_WIDTH = 16;
   localparam int REG_ADDR_WIDTH = 32;
   localparam int DI_DATA_WIDTH = 16;
   localparam int STATUS_WIDTH = 16;

   typedef logic [PIXEL_WIDTH-1:0]     pixel_t;     // u and v are taken as signed.
   typedef logic [DTYPE_WIDTH-1:0]     dtype_t;
   typedef logic [META_WIDTH-1:0]      meta_t;
   typedef logic [TERM_ADDR_WIDTH-1:0] term_addr_t;
   typedef logic [REG_ADDR_WIDTH-1:0]  reg_addr_t;
   typedef logic [DI_DATA_WIDTH-1:0]   di_data_t;
   typedef logic [STATUS_WIDTH-1:0]    status_t;

   // terminal addresses on the DI bus.
   localparam term_addr_t TERM_LOOKUP_MAP = 16'h0003;
   localparam term_addr_t TERM_CHROMA_OFFSET = 16'h0004;

   localparam status_t STATUS_OK = 16'h0000;
   localparam status_t STATUS_NO_TERM = 16'hffff;

   // chroma offset register numbers.
   localparam reg_addr_t REG_U_OFFSET = 32'd0;
   localparam reg_addr_t REG_V_OFFSET = 32'd1;

endpackage

// ==== tb/clock_gen.sv ====
module clock_gen (
   output logic di_clk,
   output logic resetb_clk
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int RESET_CYCLES = 5;

   initial begin
      di_clk = 1'b0;
      forever #5 di_clk = ~di_clk;   // 10 ns period.
   end

   initial begin
      resetb_clk = 1'b0;
      repeat (RESET_CYCLES) @(posedge di_clk);
      @(negedge di_clk);
      resetb_clk = 1'b1;   // released away from the active edge.
   end

endmodule

// ==== tb/tb_video_pipe.sv ====
module tb_video_pipe;
   timeunit 1ns;
   timeprecision 1ps;

   localparam video_pkg::term_addr_t IDLE_TERM = 16'h0000;
   localparam video_pkg::term_addr_t UNUSED_TERM = 16'h0007;
   localparam int READ_TIMEOUT = 20;
   localparam int PIPE_DEPTH = 3;

   typedef struct packed {
      logic              dv;
      video_pkg::dtype_t dtype;
      video_pkg::pixel_t y;
      video_pkg::pixel_t u;
      video_pkg::pixel_t v;
      video_pkg::meta_t  meta;
   } beat_t;

   logic                  di_clk, resetb_clk, lut_enable;
   video_pkg::term_addr_t di_term_addr;
   video_pkg::reg_addr_t  di_reg_addr;
   logic                  di_read_mode, di_read_req, di_write_mode, di_write;
   video_pkg::di_data_t   di_reg_datai, di_reg_datao;
   logic                  di_read_rdy, di_write_rdy, di_en;
   video_pkg::status_t    di_transfer_status;
   logic                  dvi, dvo;
   video_pkg::dtype_t     dtypei, dtypeo;
   video_pkg::pixel_t     y, u, v, yo, uo, vo;
   video_pkg::meta_t      meta_datai, meta_datao;

   integer            seed = 41;
   video_pkg::pixel_t lut_model [video_pkg::LUT_DEPTH];
   video_pkg::pixel_t u_off_model = '0;   // offsets come out of reset as zero.
   video_pkg::pixel_t v_off_model = '0;
   beat_t             expected_q [$];

   clock_gen u_clock_gen (.di_clk(di_clk), .resetb_clk(resetb_clk));

   video_pipe UUT (.*);

   task automatic stop_run();
      $display("Test failures found");
      $fatal(1, "simulation stopped at the first error.");
   endtask

   task automatic check_flag(input string name, input logic want, input logic got);
      if (got !== want) begin
         $display("mismatch at %0t: %s expected %b, got %b", $time, name, want, got);
         stop_run();
      end
   endtask

   task automatic check_pixel(input string name, input video_pkg::pixel_t want,
                              input video_pkg::pixel_t got);
      if (got !== want) begin
         $display("mismatch at %0t: %s expected %h, got %h", $time, name, want, got);
         stop_run();
      end
   endtask

   task automatic check_dtype(input string name, input video_pkg::dtype_t want,
                              input video_pkg::dtype_t got);
      if (got !== want) begin
         $display("mismatch at %0t: %s expected %h, got %h", $time, name, want, got);
         stop_run();
      end
   endtask

   task automatic check_meta(input string name, input video_pkg::meta_t want,
                             input video_pkg::meta_t got);
      if (got !== want) begin
         $display("mismatch at %0t: %s expected %h, got %h", $time, name, want, got);
         stop_run();
      end
   endtask

   task automatic check_data(input string name, input video_pkg::di_data_t want,
                             input video_pkg::di_data_t got);
      if (got !== want) begin
         $display("mismatch at %0t: %s expected %h, got %h", $time, name, want, got);
         stop_run();
      end
   endtask

   task automatic check_status(input string name, input video_pkg::status_t want,
                               input video_pkg::status_t got);
      if (got !== want) begin
         $display("mismatch at %0t: %s expected %h, got %h", $time, name, want, got);
         stop_run();
      end
   endtask

   // signed add of a component and its offset, held to the 8-bit signed range.
   function automatic video_pkg::pixel_t apply_offset(input video_pkg::pixel_t a,
                                                      input video_pkg::pixel_t b);
      int sum;
      sum = int'($signed(a)) + int'($signed(b));
      if (sum > 127) begin
         sum = 127;
      end else if (sum < -128) begin
         sum = -128;
      end
      return video_pkg::pixel_t'(sum);
   endfunction

   task automatic bus_write(input video_pkg::term_addr_t term, input video_pkg::reg_addr_t addr,
                            input video_pkg::di_data_t data, input logic known);
      video_pkg::status_t want_status;
      want_status = known ? video_pkg::STATUS_OK : video_pkg::STATUS_NO_TERM;
      @(negedge di_clk);
      di_term_addr = term;
      di_reg_addr = addr;
      di_reg_datai = data;
      di_write_mode = 1'b1;
      di_write = 1'b1;
      @(negedge di_clk);
      di_write = 1'b0;
      check_flag("di_en", known, di_en);
      check_flag("di_write_rdy", known, di_write_rdy);
      check_status("di_transfer_status", want_status, di_transfer_status);
      di_write_mode = 1'b0;
      di_term_addr = IDLE_TERM;
   endtask

   task automatic bus_read(input video_pkg::term_addr_t term, input video_pkg::reg_addr_t addr,
                           output video_pkg::di_data_t data);
      int waited;
      @(negedge di_clk);
      di_term_addr = term;
      di_reg_addr = addr;
      di_read_mode = 1'b1;   // address settles a cycle before the request.
      @(negedge di_clk);
      di_read_req = 1'b1;
      @(negedge di_clk);
      di_read_req = 1'b0;
      waited = 1;
      while (!di_read_rdy && waited < READ_TIMEOUT) begin
         @(negedge di_clk);
         waited++;
      end
      if (!di_read_rdy) begin
         $display("timeout: no di_read_rdy within %0d cycles of di_read_req.", READ_TIMEOUT);
         stop_run();
      end else if (waited != 1) begin
         $display("di_read_rdy came %0d cycles after di_read_req instead of one.", waited);
         stop_run();
      end
      data = di_reg_datao;
      di_read_mode = 1'b0;
      di_term_addr = IDLE_TERM;
   endtask

   task automatic set_offsets();
      video_pkg::di_data_t u_data;
      video_pkg::di_data_t v_data;
      video_pkg::di_data_t rd;
      u_data = video_pkg::di_data_t'($random(seed));
      v_data = video_pkg::di_data_t'($random(seed));
      bus_write(video_pkg::TERM_CHROMA_OFFSET, video_pkg::REG_U_OFFSET, u_data, 1'b1);
      bus_write(video_pkg::TERM_CHROMA_OFFSET, video_pkg::REG_V_OFFSET, v_data, 1'b1);
      u_off_model = u_data[7:0];
      v_off_model = v_data[7:0];
      bus_read(video_pkg::TERM_CHROMA_OFFSET, video_pkg::REG_U_OFFSET, rd);
      check_data("u offset readback", {{8{u_off_model[7]}}, u_off_model}, rd);
      bus_read(video_pkg::TERM_CHROMA_OFFSET, video_pkg::REG_V_OFFSET, rd);
      check_data("v offset readback", {{8{v_off_model[7]}}, v_off_model}, rd);
   endtask

   // streams random beats and checks each one three edges after it went in.
   task automatic run_beats(input int count, input logic lut_en);
      beat_t beat;
      beat_t want;
      expected_q.delete();
      lut_enable = lut_en;
      for (int i = 0; i < count + PIPE_DEPTH; i++) begin
         @(negedge di_clk);
         if (expected_q.size() == PIPE_DEPTH) begin
            want = expected_q.pop_front();
            check_flag("dvo", want.dv, dvo);
            check_dtype("dtypeo", want.dtype, dtypeo);
            check_pixel("yo", lut_en ? lut_model[want.y] : want.y, yo);
            check_pixel("uo", apply_offset(want.u, u_off_model), uo);
            check_pixel("vo", apply_offset(want.v, v_off_model), vo);
            check_meta("meta_datao", want.meta, meta_datao);
         end
         beat.dv = 1'($random(seed));
         beat.dtype = video_pkg::dtype_t'($random(seed));
         beat.y = video_pkg::pixel_t'($random(seed));
         beat.u = video_pkg::pixel_t'($random(seed));
         beat.v = video_pkg::pixel_t'($random(seed));
         beat.meta = video_pkg::meta_t'($random(seed));
         dvi = beat.dv;
         dtypei = beat.dtype;
         y = beat.y;
         u = beat.u;
         v = beat.v;
         meta_datai = beat.meta;
         expected_q.push_back(beat);
      end
      dvi = 1'b0;
   endtask

   initial begin
      video_pkg::di_data_t rd;
      video_pkg::di_data_t data;
      video_pkg::pixel_t   addr8;
      integer              beat_seed;
      int                  waited;
      lut_enable = 1'b0;
      di_term_addr = IDLE_TERM;
      di_reg_addr = '0;
      di_read_mode = 1'b0;
      di_read_req = 1'b0;
      di_write_mode = 1'b0;
      di_write = 1'b0;
      di_reg_datai = '0;
      dvi = 1'b0;
      dtypei = '0;
      y = '0;
      u = '0;
      v = '0;
      meta_datai = '0;

      waited = 0;
      while (!resetb_clk && waited < 20) begin
         @(negedge di_clk);
         waited++;
      end
      if (!resetb_clk) begin
         $display("timeout: resetb_clk was never released.");
         stop_run();
      end
      @(negedge di_clk);
      check_flag("dvo", 1'b0, dvo);
      check_flag("di_read_rdy", 1'b0, di_read_rdy);
      check_flag("di_write_rdy", 1'b0, di_write_rdy);
      check_flag("di_en", 1'b0, di_en);

      for (int i = 0; i < video_pkg::LUT_DEPTH; i++) begin
         data = video_pkg::di_data_t'($random(seed));
         lut_model[i] = data[7:0];
         bus_write(video_pkg::TERM_LOOKUP_MAP, video_pkg::reg_addr_t'(i), data, 1'b1);
      end
      for (int i = 0; i < 64; i++) begin
         addr8 = video_pkg::pixel_t'($random(seed));
         bus_read(video_pkg::TERM_LOOKUP_MAP, video_pkg::reg_addr_t'(addr8), rd);
         check_data("table readback", {8'h00, lut_model[addr8]}, rd);
      end

      // the same seed replays the same beats with the table bypassed.
      beat_seed = seed;
      run_beats(300, 1'b1);
      seed = beat_seed;
      run_beats(300, 1'b0);

      for (int i = 0; i < 3; i++) begin
         set_offsets();
         run_beats(300, 1'b1);
      end

      bus_write(UNUSED_TERM, video_pkg::REG_U_OFFSET, video_pkg::di_data_t'($random(seed)), 1'b0);
      bus_write(UNUSED_TERM, video_pkg::REG_V_OFFSET, video_pkg::di_data_t'($random(seed)), 1'b0);
      run_beats(300, 1'b1);
      run_beats(100, 1'b0);

      $display("All tests passed!");
      $finish;
   end

endmodule
